/* filelist.f */
zports_pkg.sv
port_decoder.sv
page_lock.sv
xt_regfile.sv
read_mux.sv
zports_top.sv
tb_clock.sv
tb_zports.sv

/* run.sh */
#!/bin/sh
# build the zports testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_zports -f filelist.f -o tb_zports_sim
./obj_dir/tb_zports_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTS PASSED" sim.log
then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

/* tb_zports.sv */
// inputs move 2 units after each rising edge; im2v_lin and im2v_dma are checked only once written
module tb_zports
	import zports_pkg::*;
();

	localparam int    N_RAND      = 3000;
	localparam int    TIMEOUT_CYC = N_RAND + 200;   // random phase plus resets and directed writes
	localparam byte_t LO_TAB  [8] = '{PORT_FE, PORT_FD, PORT_XT, PORT_FB,
		PORT_KJOY, PORT_KMOUSE, PORT_SDCFG, PORT_SDDAT};
	localparam byte_t VID_IDX [9] = '{XT_VCONF, XT_VPAGE, XT_GXOFFSL, XT_GXOFFSH,
		XT_GYOFFSL, XT_GYOFFSH, XT_TSCONF, XT_PALSEL, XT_XBORDER};
	localparam byte_t DMA_IDX [9] = '{XT_DMASADDRL, XT_DMASADDRH, XT_DMASADDRX,
		XT_DMADADDRL, XT_DMADADDRH, XT_DMADADDRX, XT_DMALEN, XT_DMACTRL, XT_DMANUM};

	logic                   clk;
	logic                   rst;
	logic [15:0]            a;
	byte_t                  din;
	logic                   iowr_s, iord_s, wr, iord, opfetch, dos, vdos;
	logic [4:0]             keys_in, kj_in;
	logic                   tape_read, dma_act;
	byte_t                  mus_in, sd_dataout;
	byte_t                  dout, sd_datain, sysconf, memconf, intmask;
	logic                   dataout, porthit, external_port, zborder_wr, beeper_wr, covox_wr;
	logic                   sdcs_n, sd_start;
	page_t [3:0]            rampage;
	logic [4:0]             fmaddr;
	logic [3:0]             fddvirt;
	logic [2:0]             im2v_frm, im2v_lin, im2v_dma;
	logic [VID_STROBES-1:0] video_wr;
	logic [DMA_STROBES-1:0] dma_wr;

	// reference model state
	page_t [3:0] m_rampage;
	byte_t       m_sysconf, m_memconf, m_intmask;
	logic [4:0]  m_fmaddr;
	logic [3:0]  m_fddvirt;
	logic [2:0]  m_frm, m_lin, m_dma;
	logic        m_lin_ok, m_dma_ok, m_sdcs_n, m_lock48, m_oplock;
	integer      seed;
	int          err_cnt [4];   // decode, strobe, register, read

	tb_clock u_clock (.clk(clk));

	zports_top dut (.*);

	function automatic logic decode_hit(logic [15:0] ad, logic d, logic vd);
		byte_t lo;
		lo = ad[7:0];
		return (lo inside {PORT_FE, PORT_XT, PORT_FD, PORT_FB, PORT_KMOUSE})
			|| (lo == PORT_KJOY && !d)
			|| ((lo inside {PORT_SDCFG, PORT_SDDAT}) && (!d || vd));
	endfunction

	function automatic logic [8:0] xt_strobes(logic [15:0] ad, logic ws, logic dma_side);
		logic [8:0] v;
		int         i;
		v = '0;
		for (i = 0; i < 9; i++)
			v[i] = ws && (ad[7:0] == PORT_XT)
				&& (ad[15:8] == (dma_side ? DMA_IDX[i] : VID_IDX[i]));
		return v;
	endfunction

	// #7FFD page value per lock mode in memconf[7:6]
	function automatic page_t bank_page(byte_t d);
		case (m_memconf[7:6])
			2'b11:   return {2'b00, d[5], d[7:6], d[2:0]};
			2'b10:   return {3'b000, m_oplock ? 2'b00 : d[7:6], d[2:0]};
			2'b01:   return {5'b00000, d[2:0]};
			default: return {3'b000, d[7:6], d[2:0]};
		endcase
	endfunction

	function automatic byte_t read_byte(logic [15:0] ad, page_t [3:0] pg);
		case (ad[7:0])
			PORT_FE: return {1'b1, tape_read, 1'b0, keys_in};
			PORT_XT:
			begin
				if (ad[15:8] == XT_DMASTAT)
					return {dma_act, 7'b0000000};
				if (ad[15:8] == XT_RAMPAGE + 8'd2 || ad[15:8] == XT_RAMPAGE + 8'd3)
					return pg[ad[9:8]];
				return 8'hFF;
			end
			PORT_KJOY:   return {3'b000, kj_in};
			PORT_KMOUSE: return mus_in;
			PORT_SDCFG:  return 8'h00;
			PORT_SDDAT:  return sd_dataout;
			default:     return 8'hFF;
		endcase
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			m_rampage <= {RAMPAGE_RST3, RAMPAGE_RST2, RAMPAGE_RST1, RAMPAGE_RST0};
			m_sysconf <= SYSCONF_RST;
			m_memconf <= MEMCONF_RST;
			m_intmask <= INTMASK_RST;
			m_fmaddr  <= '0;
			m_fddvirt <= '0;
			m_frm     <= IM2V_FRM_RST;
			m_lin_ok  <= 1'b0;
			m_dma_ok  <= 1'b0;
			m_sdcs_n  <= 1'b1;
			m_lock48  <= 1'b0;
			m_oplock  <= 1'b0;
		end
		else
		begin
			if (opfetch)
				m_oplock <= din[7] ~^ din[6];
			if (iowr_s && a[7:0] == PORT_SDCFG && (!dos || vdos))
				m_sdcs_n <= din[1];
			if (iowr_s && a[7:0] == PORT_FD && !a[15] && !m_lock48)
			begin
				m_rampage[3] <= bank_page(din);
				m_memconf[0] <= din[4];
				if (m_memconf[7:6] != 2'b11)
					m_lock48 <= din[5];   // no 48K lock in 1024K mode
			end
			else if (iowr_s && a[7:0] == PORT_XT)
			begin
				case (a[15:8])
					XT_RAMPAGE, XT_RAMPAGE + 8'd1, XT_RAMPAGE + 8'd2, XT_RAMPAGE + 8'd3:
						m_rampage[a[9:8]] <= din;
					XT_FMADDR:  m_fmaddr  <= din[4:0];
					XT_SYSCONF: m_sysconf <= din;
					XT_MEMCONF: m_memconf <= din;
					XT_FDDVIRT: m_fddvirt <= din[3:0];
					XT_INTMASK: m_intmask <= din;
					XT_IM2VECT:
					begin
						if (din[6:4] == INT_FRM)
							m_frm <= din[3:1];
						if (din[6:4] == INT_LIN)
						begin
							m_lin    <= din[3:1];
							m_lin_ok <= 1'b1;
						end
						if (din[6:4] == INT_DMA)
						begin
							m_dma    <= din[3:1];
							m_dma_ok <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	task automatic log_mismatch(input int kind, input string msg);
		err_cnt[kind]++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	a_reset: assert property (@(posedge clk) $fell(rst) |-> (rampage == {RAMPAGE_RST3,
		RAMPAGE_RST2, RAMPAGE_RST1, RAMPAGE_RST0}) && sysconf == SYSCONF_RST
		&& memconf == MEMCONF_RST && intmask == INTMASK_RST && im2v_frm == IM2V_FRM_RST
		&& sdcs_n && fmaddr == '0 && fddvirt == '0)
		else log_mismatch(2, "register not at reset value after rst");

	a_idle: assert property (@(posedge clk) !(iowr_s || iord_s) |-> !(|video_wr)
		&& !(|dma_wr) && !zborder_wr && !beeper_wr && !covox_wr && !sd_start)
		else log_mismatch(1, "strobe active without iowr_s or iord_s");

	a_decode: assert property (@(posedge clk) disable iff (rst)
		porthit == decode_hit(a, dos, vdos)
		&& external_port == (a[7:0] == PORT_FD && a[15])
		&& dataout == (decode_hit(a, dos, vdos) && iord && !(a[7:0] == PORT_FD && a[15])))
		else log_mismatch(0, "porthit, external_port or dataout wrong");

	a_strobes: assert property (@(posedge clk) disable iff (rst)
		video_wr == xt_strobes(a, iowr_s, 1'b0) && dma_wr == xt_strobes(a, iowr_s, 1'b1)
		&& zborder_wr == (iowr_s && a[7:0] == PORT_FE)
		&& beeper_wr == (iowr_s && a[7:0] == PORT_FE)
		&& covox_wr == (iowr_s && a[7:0] == PORT_FB)
		&& sd_start == (a[7:0] == PORT_SDDAT && (iord_s || (iowr_s && (!dos || vdos)))))
		else log_mismatch(1, "write strobe vector wrong");

	a_regs: assert property (@(posedge clk) disable iff (rst)
		rampage == m_rampage && sysconf == m_sysconf && memconf == m_memconf
		&& fmaddr == m_fmaddr && fddvirt == m_fddvirt && intmask == m_intmask
		&& im2v_frm == m_frm && (!m_lin_ok || im2v_lin == m_lin)
		&& (!m_dma_ok || im2v_dma == m_dma) && sdcs_n == m_sdcs_n)
		else log_mismatch(2, "register output differs from model");

	a_read: assert property (@(posedge clk) disable iff (rst)
		dout == read_byte(a, m_rampage) && sd_datain == (wr ? din : 8'hFF))
		else log_mismatch(3, "read data or sd_datain wrong");

	task automatic set_bus(logic [15:0] ad, byte_t d, logic ws, logic rs, logic of);
		a       = ad;
		din     = d;
		iowr_s  = ws;
		iord_s  = rs;
		wr      = ws;
		iord    = rs;
		opfetch = of;
	endtask

	task automatic drive(logic [15:0] ad, byte_t d, logic ws, logic rs, logic of);
		@(posedge clk);
		#2;
		set_bus(ad, d, ws, rs, of);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		set_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	task automatic drive_random();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		byte_t       lo;
		byte_t       hi;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		case (r1[4:3])
			2'b00:   lo = PORT_XT;   // extra weight on #nnAF
			2'b11:   lo = r1[15:8];
			default: lo = LO_TAB[r1[2:0]];
		endcase
		hi = r1[16] ? r1[31:24] : {2'b00, r1[22:17]};
		drive({hi, lo}, r2[7:0], r2[8], r2[9], r2[12:10] == 3'b000);
		wr         = r2[13];
		iord       = r2[14];
		dos        = r2[15];
		vdos       = r2[16];
		keys_in    = r2[21:17];
		tape_read  = r2[22];
		kj_in      = r2[27:23];
		dma_act    = r2[28];
		mus_in     = r3[7:0];
		sd_dataout = r3[15:8];
	endtask

	initial
	begin
		int          m;
		int          k;
		logic [31:0] r;
		seed    = 32'hd699f346;
		err_cnt = '{0, 0, 0, 0};
		dos        = 1'b0;
		vdos       = 1'b0;
		keys_in    = 5'h1F;
		kj_in      = 5'h00;
		tape_read  = 1'b0;
		dma_act    = 1'b0;
		mus_in     = 8'hFF;
		sd_dataout = 8'hFF;
		apply_reset();
		repeat (N_RAND)
			drive_random();
		apply_reset();   // clears lock48 before the lock mode sweep
		// a distinct vector per source
		for (k = 0; k < 3; k++)
			drive({XT_IM2VECT, PORT_XT}, {1'b0, k[2:0], k[2:0] + 3'd3, 1'b0},
				1'b1, 1'b0, 1'b0);
		for (m = 0; m < 4; m++)
			for (k = 0; k < 2; k++)
			begin
				drive({XT_MEMCONF, PORT_XT}, {m[1:0], 6'h04}, 1'b1, 1'b0, 1'b0);
				drive(16'h0000, k[0] ? 8'h40 : 8'h00, 1'b0, 1'b0, 1'b1);   // opcode fetch
				r = $random(seed);
				// bit 5 only in 1024K mode, where it is a bank bit
				drive({8'h7F, PORT_FD}, m == 3 ? r[7:0] | 8'hA0 : (r[7:0] & 8'hDF) | 8'h80,
					1'b1, 1'b0, 1'b0);
			end
		drive({XT_MEMCONF, PORT_XT}, 8'h04, 1'b1, 1'b0, 1'b0);
		drive({8'h7F, PORT_FD}, 8'h27, 1'b1, 1'b0, 1'b0);   // takes the 48K lock
		drive({8'h7F, PORT_FD}, 8'hD3, 1'b1, 1'b0, 1'b0);
		drive({8'h7F, PORT_FD}, 8'h05, 1'b1, 1'b0, 1'b0);
		drive(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		repeat (2) @(posedge clk);
		$display("error counts: decode %0d, strobe %0d, register %0d, read %0d",
			err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
		if (err_cnt.sum() == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_CYC * 40);
		$display("watchdog expired, stimulus did not finish within %0d cycles", TIMEOUT_CYC);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb_clock.sv */
// free-running clock that starts low; PERIOD must be even
module tb_clock
#(
	parameter int PERIOD = 40
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

/* zports_top.sv */
// single clk domain; iowr_s and iord_s arrive already synchronized as one-cycle strobes
module zports_top
	import zports_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [15:0]            a,
	input  byte_t                  din,
	input  logic                   iowr_s,
	input  logic                   iord_s,
	input  logic                   wr,
	input  logic                   iord,
	input  logic                   opfetch,
	input  logic                   dos,
	input  logic                   vdos,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	input  logic [4:0]             kj_in,
	input  byte_t                  mus_in,
	input  byte_t                  sd_dataout,
	input  logic                   dma_act,
	output byte_t                  dout,
	output logic                   dataout,
	output logic                   porthit,
	output logic                   external_port,
	output page_t [3:0]            rampage,
	output byte_t                  sysconf,
	output byte_t                  memconf,
	output logic [4:0]             fmaddr,
	output logic [3:0]             fddvirt,
	output logic [2:0]             im2v_frm,
	output logic [2:0]             im2v_lin,
	output logic [2:0]             im2v_dma,
	output byte_t                  intmask,
	output logic                   zborder_wr,
	output logic                   beeper_wr,
	output logic                   covox_wr,
	output logic [VID_STROBES-1:0] video_wr,
	output logic [DMA_STROBES-1:0] dma_wr,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output byte_t                  sd_datain
);

	logic  p7ffd_hit;
	logic  p7ffd_wr;
	page_t p7ffd_page;
	logic  rom_sel;
	logic  xt_wr;
	logic  fe_wr;
	logic  sdcfg_wr;

	// one FE write feeds border and beeper
	assign zborder_wr = fe_wr;
	assign beeper_wr  = fe_wr;

	port_decoder u_decoder (.*);

	page_lock u_lock (
		.lock_mode (memconf[7:6]),
		.*
	);

	xt_regfile u_regs (
		.hoa (a[15:8]),
		.*
	);

	read_mux u_rdmux (
		.rampage2 (rampage[2]),
		.rampage3 (rampage[3]),
		.*
	);

endmodule

/* read_mux.sv */
// dout is valid for any address; only dataout says whether the Z80 bus is driven
module read_mux
	import zports_pkg::*;
(
	input  logic [15:0] a,
	input  byte_t       din,
	input  logic        wr,
	input  logic        iord,
	input  logic        porthit,
	input  logic        external_port,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  byte_t       mus_in,
	input  byte_t       sd_dataout,
	input  logic        dma_act,
	input  page_t       rampage2,
	input  page_t       rampage3,
	output byte_t       dout,
	output logic        dataout,
	output byte_t       sd_datain
);

	byte_t loa;
	byte_t hoa;

	assign loa = a[7:0];
	assign hoa = a[15:8];

	always_comb
	begin
		case (loa)
			PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_XT:
			begin
				case (hoa)
					XT_DMASTAT:        dout = {dma_act, 7'b0};
					XT_RAMPAGE + 8'd2: dout = rampage2;
					XT_RAMPAGE + 8'd3: dout = rampage3;
					default:           dout = 8'hFF;   // XSTAT included
				endcase
			end
			PORT_KJOY:   dout = {3'b000, kj_in};
			PORT_KMOUSE: dout = mus_in;
			PORT_SDCFG:  dout = 8'h00;   // card present, not write protected
			PORT_SDDAT:  dout = sd_dataout;
			default:     dout = 8'hFF;
		endcase
	end

	// external chips drive the bus themselves
	assign dataout = porthit && iord && !external_port;

	// SPI shifts ones out on a read
	assign sd_datain = wr ? din : 8'hFF;

endmodule

/* xt_regfile.sv */
// writes land on the clk edge after the strobe; #7FFD wins over #nnAF in the same cycle
module xt_regfile
	import zports_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  byte_t       din,
	input  byte_t       hoa,
	input  logic        xt_wr,
	input  logic        p7ffd_wr,
	input  page_t       p7ffd_page,
	input  logic        rom_sel,
	input  logic        sdcfg_wr,
	output page_t [3:0] rampage,
	output byte_t       sysconf,
	output byte_t       memconf,
	output logic  [4:0] fmaddr,
	output logic  [3:0] fddvirt,
	output logic  [2:0] im2v_frm,
	output logic  [2:0] im2v_lin,
	output logic  [2:0] im2v_dma,
	output byte_t       intmask,
	output logic        sdcs_n
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage[0] <= RAMPAGE_RST0;
			rampage[1] <= RAMPAGE_RST1;
			rampage[2] <= RAMPAGE_RST2;
			rampage[3] <= RAMPAGE_RST3;
			sysconf    <= SYSCONF_RST;
			memconf    <= MEMCONF_RST;
			fmaddr     <= '0;
			fddvirt    <= '0;
			intmask    <= INTMASK_RST;
			im2v_frm   <= IM2V_FRM_RST;
			// line and DMA vectors are set by software before use
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= rom_sel;      // ROM select mirrors into memconf
			rampage[3] <= p7ffd_page;   // #C000 window
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == XT_RAMPAGE[7:2])
				rampage[hoa[1:0]] <= din;

			case (hoa)
				XT_FMADDR:  fmaddr  <= din[4:0];
				XT_SYSCONF: sysconf <= din;
				XT_MEMCONF: memconf <= din;
				XT_FDDVIRT: fddvirt <= din[3:0];
				XT_INTMASK: intmask <= din;
				XT_IM2VECT:
				begin
					// din[6:4] picks the source, din[3:1] is the vector
					case (din[6:4])
						INT_FRM: im2v_frm <= din[3:1];
						INT_LIN: im2v_lin <= din[3:1];
						INT_DMA: im2v_dma <= din[3:1];
					endcase
				end
			endcase
		end
	end

	// SD chip select, card deselected out of reset
	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (sdcfg_wr)
			sdcs_n <= din[1];
	end

	// the memory map must come up with ROM unmapped after any reset
	a_memconf_rst: assert property (@(posedge clk) rst |=> (memconf == MEMCONF_RST))
		else $error("xt_regfile: memconf not at reset value after rst");

endmodule

/* page_lock.sv */
// lock_mode is memconf[7:6]; opfetch is a one-cycle pulse with the fetched opcode on din
module page_lock
	import zports_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  byte_t      din,
	input  logic       opfetch,
	input  logic       p7ffd_hit,
	input  logic [1:0] lock_mode,
	output logic       p7ffd_wr,
	output page_t      p7ffd_page,
	output logic       rom_sel
);

	logic       lock48;    // 48K lock, set by #7FFD bit 5
	logic       m1_lock;   // opcode based 128K lock for mode 2
	logic       mode3;
	logic       lock128;
	logic [2:0] bank_hi;

	assign mode3 = (lock_mode == 2'b11);

	// mode 2 takes the opcode latch, modes 0 and 1 follow memconf bit 6
	assign lock128 = (lock_mode == 2'b10) ? m1_lock : lock_mode[0];

	// mode 3 gives 1024K: bit 5 becomes the top bank bit
	assign bank_hi = mode3 ? {din[5], din[7:6]} : {1'b0, lock128 ? 2'b00 : din[7:6]};

	assign p7ffd_page = {2'b00, bank_hi, din[2:0]};
	assign p7ffd_wr   = p7ffd_hit && !lock48;
	assign rom_sel    = din[4];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lock48  <= 1'b0;
			m1_lock <= 1'b0;
		end
		else
		begin
			if (p7ffd_wr && !mode3)
				lock48 <= din[5];
			if (opfetch)
				m1_lock <= !(din[7] ^ din[6]);
		end
	end

	// once 48K lock is taken the port stays shut on the next cycle
	a_lock48: assert property (@(posedge clk) disable iff (rst)
		(p7ffd_wr && din[5] && !mode3) |=> !p7ffd_wr)
		else $error("page_lock: #7FFD write passed a set 48K lock");

endmodule

/* port_decoder.sv */
// pure decode; iowr_s and iord_s must be one clk wide, a must be stable while they are high
module port_decoder
	import zports_pkg::*;
(
	input  logic [15:0]            a,
	input  logic                   dos,
	input  logic                   vdos,
	input  logic                   iowr_s,
	input  logic                   iord_s,
	output logic                   porthit,
	output logic                   external_port,
	output logic                   p7ffd_hit,
	output logic                   xt_wr,
	output logic                   fe_wr,
	output logic                   covox_wr,
	output logic                   sdcfg_wr,
	output logic                   sd_start,
	output logic [VID_STROBES-1:0] video_wr,
	output logic [DMA_STROBES-1:0] dma_wr
);

	byte_t loa;
	byte_t hoa;
	logic  sd_en;    // SD ports hidden in dos unless virtual dos

	assign loa   = a[7:0];
	assign hoa   = a[15:8];
	assign sd_en = !dos || vdos;

	assign porthit = (loa == PORT_FE) || (loa == PORT_XT) || (loa == PORT_FD)
		|| (loa == PORT_FB)
		|| ((loa == PORT_KJOY) && !dos)
		|| (loa == PORT_KMOUSE)
		|| (((loa == PORT_SDCFG) || (loa == PORT_SDDAT)) && sd_en);

	// AY lives on the sound board
	assign external_port = (loa == PORT_FD) && a[15];

	assign p7ffd_hit = (loa == PORT_FD) && !a[15] && iowr_s;   // lock applied later
	assign xt_wr     = (loa == PORT_XT) && iowr_s;
	assign fe_wr     = (loa == PORT_FE) && iowr_s;
	assign covox_wr  = (loa == PORT_FB) && iowr_s;
	assign sdcfg_wr  = (loa == PORT_SDCFG) && iowr_s && sd_en;

	// reads of SDDAT start a transfer regardless of dos
	assign sd_start = (loa == PORT_SDDAT) && ((iowr_s && sd_en) || iord_s);

	always_comb
	begin
		video_wr = '0;
		dma_wr   = '0;
		if (xt_wr)
		begin
			case (hoa)
				XT_VCONF:     video_wr[VS_VCONF]   = 1'b1;
				XT_VPAGE:     video_wr[VS_VPAGE]   = 1'b1;
				XT_GXOFFSL:   video_wr[VS_GXOFFSL] = 1'b1;
				XT_GXOFFSH:   video_wr[VS_GXOFFSH] = 1'b1;
				XT_GYOFFSL:   video_wr[VS_GYOFFSL] = 1'b1;
				XT_GYOFFSH:   video_wr[VS_GYOFFSH] = 1'b1;
				XT_TSCONF:    video_wr[VS_TSCONF]  = 1'b1;
				XT_PALSEL:    video_wr[VS_PALSEL]  = 1'b1;
				XT_XBORDER:   video_wr[VS_XBORDER] = 1'b1;
				XT_DMASADDRL: dma_wr[0] = 1'b1;
				XT_DMASADDRH: dma_wr[1] = 1'b1;
				XT_DMASADDRX: dma_wr[2] = 1'b1;
				XT_DMADADDRL: dma_wr[3] = 1'b1;
				XT_DMADADDRH: dma_wr[4] = 1'b1;
				XT_DMADADDRX: dma_wr[5] = 1'b1;
				XT_DMALEN:    dma_wr[6] = 1'b1;
				XT_DMACTRL:   dma_wr[7] = 1'b1;
				XT_DMANUM:    dma_wr[8] = 1'b1;
			endcase
		end
	end

	// falling edge of the write strobe samples the decode of the strobe cycle;
	// the video and DMA banks must never see two strobes from one write
	a_one_strobe: assert property (@(negedge iowr_s)
		$onehot0(video_wr) && $onehot0(dma_wr) && !((|video_wr) && (|dma_wr)))
		else $error("port_decoder: more than one #nnAF strobe in one write");

endmodule

/* zports_pkg.sv */
// port map and #nnAF index table; indices are full high-byte matches, no partial decode
package zports_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] page_t;    // RAM page number

	// low address byte of each port
	localparam byte_t PORT_FE     = 8'hFE;   // keyboard, tape, border
	localparam byte_t PORT_FD     = 8'hFD;   // #7FFD paging when a15 low, AY otherwise
	localparam byte_t PORT_XT     = 8'hAF;   // extended registers
	localparam byte_t PORT_FB     = 8'hFB;   // covox
	localparam byte_t PORT_KJOY   = 8'h1F;
	localparam byte_t PORT_KMOUSE = 8'hDF;
	localparam byte_t PORT_SDCFG  = 8'h77;
	localparam byte_t PORT_SDDAT  = 8'h57;

	// #nnAF indices, video side
	localparam byte_t XT_VCONF    = 8'h00;
	localparam byte_t XT_VPAGE    = 8'h01;
	localparam byte_t XT_GXOFFSL  = 8'h02;
	localparam byte_t XT_GXOFFSH  = 8'h03;
	localparam byte_t XT_GYOFFSL  = 8'h04;
	localparam byte_t XT_GYOFFSH  = 8'h05;
	localparam byte_t XT_TSCONF   = 8'h06;
	localparam byte_t XT_PALSEL   = 8'h07;
	localparam byte_t XT_XBORDER  = 8'h0F;

	// #nnAF indices held in this block
	localparam byte_t XT_RAMPAGE  = 8'h10;   // #10..#13
	localparam byte_t XT_FMADDR   = 8'h15;
	localparam byte_t XT_SYSCONF  = 8'h20;
	localparam byte_t XT_MEMCONF  = 8'h21;
	localparam byte_t XT_IM2VECT  = 8'h25;
	localparam byte_t XT_FDDVIRT  = 8'h29;
	localparam byte_t XT_INTMASK  = 8'h2A;

	// DMA register bank
	localparam byte_t XT_DMASADDRL = 8'h1A;
	localparam byte_t XT_DMASADDRH = 8'h1B;
	localparam byte_t XT_DMASADDRX = 8'h1C;
	localparam byte_t XT_DMADADDRL = 8'h1D;
	localparam byte_t XT_DMADADDRH = 8'h1E;
	localparam byte_t XT_DMADADDRX = 8'h1F;
	localparam byte_t XT_DMALEN    = 8'h26;
	localparam byte_t XT_DMACTRL   = 8'h27;
	localparam byte_t XT_DMANUM    = 8'h28;
	localparam byte_t XT_DMASTAT   = 8'h27;  // read side of DMACTRL

	// vector selector in din[6:4] of an IM2VECT write
	localparam logic [2:0] INT_FRM = 3'b000;
	localparam logic [2:0] INT_LIN = 3'b001;
	localparam logic [2:0] INT_DMA = 3'b010;

	localparam int VID_STROBES = 9;
	localparam int VS_VCONF    = 0;
	localparam int VS_VPAGE    = 1;
	localparam int VS_GXOFFSL  = 2;
	localparam int VS_GXOFFSH  = 3;
	localparam int VS_GYOFFSL  = 4;
	localparam int VS_GYOFFSH  = 5;
	localparam int VS_TSCONF   = 6;
	localparam int VS_PALSEL   = 7;
	localparam int VS_XBORDER  = 8;

	localparam int DMA_STROBES = 9;   // sl, sh, sx, dl, dh, dx, len, ctrl, num

	localparam byte_t      SYSCONF_RST  = 8'h01;   // turbo 7 MHz
	localparam byte_t      MEMCONF_RST  = 8'h04;   // no ROM map
	localparam byte_t      INTMASK_RST  = 8'h01;   // frame int only
	localparam logic [2:0] IM2V_FRM_RST = 3'b111;
	localparam page_t      RAMPAGE_RST0 = 8'h00;
	localparam page_t      RAMPAGE_RST1 = 8'h05;
	localparam page_t      RAMPAGE_RST2 = 8'h02;
	localparam page_t      RAMPAGE_RST3 = 8'h00;

endpackage
